// ==== Makefile ====
# Verilator build and run of the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= ifu_tb
FILELIST  ?= ifu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard rtl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the output
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/ifu_checker.sv ====
`timescale 1ns/1ps

module ifu_checker import ifu_pkg::*, wb_pkg::*; (
   input logic          clock,
   input logic          rst_n,
   input wb_req_t       wb_req,
   input wb_rsp_t       wb_rsp,
   input logic          stall,
   input fetch_bundle_t dec,
   input logic          dec_valid
);

   // read by the testbench at the end of the run
   int unsigned fail_cnt = 0;

   // ========================================================================
   // wishbone classic master rules
   // ========================================================================

   // stb only inside a bus cycle
   stb_in_cyc: assert property (@(posedge clock) disable iff (!rst_n)
      wb_req.stb |-> wb_req.cyc)
      else begin
         fail_cnt = fail_cnt + 1;
         $error("stb high without cyc");
      end

   // address held until the slave answers
   adr_hold: assert property (@(posedge clock) disable iff (!rst_n)
      wb_req.cyc && !(wb_rsp.ack || wb_rsp.err) |=> $stable(wb_req.adr))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("adr changed inside an open bus cycle");
      end

   // bus quiet in reset, once reset has been seen for a full cycle
   idle_in_reset: assert property (@(posedge clock)
      !rst_n && $past(!rst_n) |-> !wb_req.cyc)
      else begin
         fail_cnt = fail_cnt + 1;
         $error("cyc high while rst_n is low");
      end

   // ========================================================================
   // decode handoff
   // ========================================================================

   // decode sees a frozen item under back-pressure
   dec_hold: assert property (@(posedge clock) disable iff (!rst_n)
      dec_valid && stall |=> $stable(dec))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("dec changed while stalled");
      end

endmodule

bind ifu_top ifu_checker u_chk (
   .clock     (clock),
   .rst_n     (rst_n),
   .wb_req    (wb_req),
   .wb_rsp    (wb_rsp),
   .stall     (stall),
   .dec       (dec),
   .dec_valid (dec_valid)
);

// ==== dv/ifu_clock_gen.sv ====
`timescale 1ns/1ps

module ifu_clock_gen #(
   parameter int period_ns = 20
) (
   output logic clock
);

   // free running, starts low so the first rising edge is at half a period
   initial begin
      clock = 1'b0;
      forever begin
         #(period_ns / 2) clock = ~clock;
      end
   end

endmodule

// ==== dv/ifu_imem_model.sv ====
`timescale 1ns/1ps

module ifu_imem_model import wb_pkg::*; #(
   parameter logic [31:0] data_key = 32'h0,
   parameter logic [31:0] err_lo   = 32'hffff_fff0,
   parameter logic [31:0] err_hi   = 32'hffff_fff0
) (
   input  logic    clock,
   input  logic    rst_n,
   input  wb_req_t wb_req,
   output wb_rsp_t wb_rsp
);

   logic        ack_q = 1'b0;
   logic        err_q = 1'b0;
   logic [31:0] dat_q = '0;
   logic        in_window;

   // word range that answers with err
   assign in_window = (wb_req.adr >= err_lo) && (wb_req.adr <= err_hi);

   // one wait state, answer the cycle after stb is seen
   // no second answer while the current one is still on the bus
   always @(posedge clock) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
         if (wb_req.cyc && wb_req.stb && !ack_q && !err_q) begin
            ack_q <= ~in_window;
            err_q <= in_window;
         end
      end
   end

   // contents computed from the full address
   always @(posedge clock) begin
      if (wb_req.cyc && wb_req.stb && !ack_q && !err_q) begin
         dat_q <= in_window ? 32'h0 : (wb_req.adr ^ data_key);
      end
   end

   assign wb_rsp.ack = ack_q;
   assign wb_rsp.err = err_q;
   assign wb_rsp.dat = dat_q;

endmodule

// ==== dv/ifu_tb.sv ====
`timescale 1ns/1ps
`include "ifu_settings.svh"

module ifu_tb import ifu_pkg::*, wb_pkg::*; ();

   localparam int          clk_period   = 20;
   localparam int          num_tests    = 5;
   localparam int unsigned item_timeout = 300;
   localparam logic [31:0] data_key     = 32'h5a3c_96e1;
   // two faulting words
   localparam logic [31:0] err_lo       = 32'h1c00_4000;
   localparam logic [31:0] err_hi       = 32'h1c00_4004;

   logic          clock;
   logic          rst_n;
   wb_req_t       wb_req;
   wb_rsp_t       wb_rsp;
   redirect_t     redirect;
   logic          stall;
   fetch_bundle_t dec;
   logic          dec_valid;
   addr_t         pc_e;
   addr_t         pc_w;
   logic          pc_w_valid;

   logic [31:0]   lfsr;
   addr_t         exp_pc;
   // items taken by decode in order
   fetch_bundle_t acc_q[$];
   // taken pcs still on their way to writeback
   // and the stall free count at the take
   addr_t         wb_pc_q[$];
   int unsigned   wb_stamp_q[$];
   // pc of the item taken at the previous edge, due on pc_e
   addr_t         took_pc;
   logic          took_last = 1'b0;
   int unsigned   acc_cnt   = 0;
   int unsigned   pop_cnt   = 0;
   int unsigned   kill_at   = 0;
   int unsigned   free_cnt  = 0;
   int unsigned   wb_done   = 0;
   int unsigned   value_cnt = 0;
   int unsigned   miss_cnt  = 0;
   int unsigned   total_err;
   logic          last_free = 1'b0;

   ifu_clock_gen #(.period_ns(clk_period)) u_clk (.clock(clock));

   ifu_imem_model #(.data_key(data_key), .err_lo(err_lo), .err_hi(err_hi)) u_mem (
      .clock  (clock),
      .rst_n  (rst_n),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp)
   );

   ifu_top dut0 (
      .clock      (clock),
      .rst_n      (rst_n),
      .wb_req     (wb_req),
      .wb_rsp     (wb_rsp),
      .redirect   (redirect),
      .stall      (stall),
      .dec        (dec),
      .dec_valid  (dec_valid),
      .pc_e       (pc_e),
      .pc_w       (pc_w),
      .pc_w_valid (pc_w_valid)
   );

   // ========================================================================
   // stimulus helpers
   // ========================================================================

   // fibonacci lfsr with taps 32 22 2 1
   // one step per bit
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   // word aligned target with 12 random bits above the base
   function automatic addr_t rand_target(addr_t base);
      logic [31:0] bits;
      bits = '0;
      repeat (12) begin
         bits = {bits[30:0], lfsr_bit()};
      end
      return base | (bits << 2);
   endfunction

   // what the memory answers for a pc
   function automatic fetch_bundle_t expect_bundle(addr_t pc);
      fetch_bundle_t b;
      b.pc = pc;
      if (pc >= err_lo && pc <= err_hi) begin
         b.inst    = '0;
         b.ex      = 1'b1;
         b.exccode = `IFU_EXC_FETCH_ERR;
      end else begin
         b.inst    = pc ^ data_key;
         b.ex      = 1'b0;
         b.exccode = '0;
      end
      return b;
   endfunction

   // ========================================================================
   // compare tasks
   // ========================================================================

   task automatic check_bundle(fetch_bundle_t got, fetch_bundle_t exp, string what);
      if (got !== exp) begin
         value_cnt++;
         $display("FAILED time %0t: %s got pc %h inst %h ex %b code %h", $time, what,
                  got.pc, got.inst, got.ex, got.exccode);
         $display("FAILED time %0t: %s expected pc %h inst %h ex %b code %h", $time,
                  what, exp.pc, exp.inst, exp.ex, exp.exccode);
      end
   endtask

   task automatic check_pc(addr_t got, addr_t exp, string what);
      if (got !== exp) begin
         value_cnt++;
         $display("FAILED time %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // ========================================================================
   // monitor sampling settled values on the rising edge
   // ========================================================================

   always @(posedge clock) begin
      addr_t       exp_w;
      int unsigned stamp;
      if (rst_n) begin
         // the item taken one edge earlier now sits in d2e
         if (took_last) begin
            check_pc(pc_e, took_pc, "pc_e after take");
         end
         // fresh writeback item only after a stall free load
         if (pc_w_valid && last_free) begin
            if (wb_pc_q.size() == 0) begin
               miss_cnt++;
               $display("pc_w showed an item that decode never took, at %0t", $time);
            end else begin
               exp_w = wb_pc_q.pop_front();
               stamp = wb_stamp_q.pop_front();
               wb_done++;
               check_pc(pc_w, exp_w, "pc_w order");
               if (free_cnt != stamp + 3) begin
                  value_cnt++;
                  $display("FAILED time %0t: pc_w %h after %0d stall free cycles, not 3",
                           $time, exp_w, free_cnt - stamp);
               end
            end
         end
         took_last = dec_valid && !stall;
         if (dec_valid && !stall) begin
            acc_q.push_back(dec);
            acc_cnt++;
            wb_pc_q.push_back(dec.pc);
            wb_stamp_q.push_back(free_cnt);
            took_pc = dec.pc;
         end
         // items up to here belong to the old path
         if (redirect.except || redirect.ertn || redirect.br_taken) begin
            kill_at = acc_cnt;
         end
         last_free = ~stall;
         if (!stall) begin
            free_cnt++;
         end
      end else begin
         last_free = 1'b0;
         took_last = 1'b0;
      end
   end

   // ========================================================================
   // stream handling on the falling edge
   // ========================================================================

   task automatic take_item(output fetch_bundle_t item, output bit ok);
      int unsigned waited;
      waited = 0;
      while (acc_q.size() == 0 && waited < item_timeout) begin
         @(negedge clock);
         waited++;
      end
      if (acc_q.size() == 0) begin
         miss_cnt++;
         $display("no item taken by decode within %0d cycles (next pc %h), at %0t",
                  item_timeout, exp_pc, $time);
         item = '0;
         ok   = 1'b0;
      end else begin
         item = acc_q.pop_front();
         pop_cnt++;
         ok   = 1'b1;
      end
   endtask

   // next items must follow exp_pc word by word
   task automatic check_stream(int unsigned count, string what);
      fetch_bundle_t got;
      bit            ok;
      for (int unsigned i = 0; i < count; i++) begin
         take_item(got, ok);
         if (!ok) begin
            return;
         end
         check_bundle(got, expect_bundle(exp_pc), what);
         exp_pc = exp_pc + 32'd4;
      end
   endtask

   // one cycle pulse
   // drain the old path and then follow the target
   task automatic follow_redirect(redirect_t r, addr_t target, string what);
      fetch_bundle_t got;
      bit            ok;
      @(posedge clock);
      redirect <= r;
      @(posedge clock);
      redirect <= '0;
      @(negedge clock);
      while (pop_cnt < kill_at) begin
         take_item(got, ok);
         if (!ok) begin
            break;
         end
         check_bundle(got, expect_bundle(exp_pc), {what, " old path"});
         exp_pc = exp_pc + 32'd4;
      end
      exp_pc = target;
      check_stream(6, what);
   endtask

   // ========================================================================
   // directed tests
   // ========================================================================

   task automatic reset_stream();
      @(negedge clock);
      check_stream(8, "reset stream");
   endtask

   task automatic branch_redirect();
      redirect_t r;
      r           = '0;
      r.br_taken  = 1'b1;
      r.br_target = rand_target(32'h1c01_0000);
      follow_redirect(r, r.br_target, "branch");
   endtask

   // all three flags first and then ertn with a branch
   task automatic redirect_priority();
      redirect_t r;
      r           = '0;
      r.except    = 1'b1;
      r.ertn      = 1'b1;
      r.br_taken  = 1'b1;
      r.eentry    = rand_target(32'h1c02_0000);
      r.era       = rand_target(32'h1c03_0000);
      r.br_target = rand_target(32'h1c01_0000);
      follow_redirect(r, r.eentry, "except over ertn and branch");
      r.except    = 1'b0;
      r.era       = rand_target(32'h1c03_0000);
      r.br_target = rand_target(32'h1c01_0000);
      follow_redirect(r, r.era, "ertn over branch");
   endtask

   task automatic stall_stream();
      fork
         begin
            repeat (200) begin
               @(posedge clock);
               stall <= lfsr_bit();
            end
            @(posedge clock);
            stall <= 1'b0;
         end
         begin
            @(negedge clock);
            check_stream(20, "random stall");
         end
      join
   endtask

   // lands two words before the faulting words
   task automatic error_window_fetch();
      redirect_t r;
      r           = '0;
      r.br_taken  = 1'b1;
      r.br_target = err_lo - 32'd8;
      follow_redirect(r, r.br_target, "error window");
   endtask

   // ========================================================================
   // watchdog
   // ========================================================================

   initial begin
      #(num_tests * 400 * clk_period);
      $display("watchdog expired before the tests completed, at %0t", $time);
      $display("Finished with errors");
      $finish;
   end

   // ========================================================================
   // main sequence
   // ========================================================================

   initial begin
      rst_n    = 1'b0;
      stall    = 1'b0;
      redirect = '0;
      lfsr     = 32'h6f52;
      exp_pc   = `IFU_RESET_PC;
      repeat (5) @(posedge clock);
      rst_n <= 1'b1;

      reset_stream();
      branch_redirect();
      redirect_priority();
      stall_stream();
      error_window_fetch();

      // at most d2e, e2m and m2w still in flight
      @(negedge clock);
      if (wb_done == 0 || wb_pc_q.size() > 3) begin
         miss_cnt++;
         $display("pc trail lost items: %0d reached pc_w, %0d still pending",
                  wb_done, wb_pc_q.size());
      end

      total_err = value_cnt + miss_cnt + dut0.u_chk.fail_cnt;
      $display("errors: %0d wrong values, %0d missing items, %0d assertion failures",
               value_cnt, miss_cnt, dut0.u_chk.fail_cnt);
      if (total_err == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== ifu.f ====
+incdir+rtl
rtl/ifu_pkg.sv
rtl/wb_pkg.sv
rtl/ifu_pc_select.sv
rtl/ifu_wb_fetch.sv
rtl/ifu_stage_reg.sv
rtl/ifu_top.sv
dv/ifu_clock_gen.sv
dv/ifu_imem_model.sv
dv/ifu_checker.sv
dv/ifu_tb.sv

// ==== rtl/ifu_pc_select.sv ====
`timescale 1ns/1ps
`include "ifu_settings.svh"

module ifu_pc_select import ifu_pkg::*; (
   input  logic      clock,
   input  logic      rst_n,
   input  redirect_t redirect,
   input  logic      fetch_done,
   output addr_t     fetch_pc
);

   // width of the word index above the byte offset
   localparam int unsigned word_w = `IFU_XLEN - 2;

   // source selects, at most one high
   logic sel_exc;
   logic sel_ertn;
   logic sel_br;
   logic sel_inc;

   addr_t             pc_q;
   addr_t             pc_inc;
   addr_t             pc_next;
   logic [word_w-1:0] word_inc;

   // ========================================================================
   // sequential increment
   // ========================================================================

   // 30 bit incrementer on the word index
   assign word_inc = pc_q[`IFU_XLEN-1:2] + {{(word_w-1){1'b0}}, 1'b1};

   // byte offset passes through untouched
   assign pc_inc = {word_inc, pc_q[1:0]};

   // ========================================================================
   // priority choice
   // ========================================================================

   // exception entry first
   assign sel_exc = redirect.except;
   // then exception return
   assign sel_ertn = ~redirect.except & redirect.ertn;
   // then a taken branch
   assign sel_br = ~redirect.except & ~redirect.ertn & redirect.br_taken;
   // +4 only once the buffered word went to decode
   assign sel_inc = ~redirect.except & ~redirect.ertn & ~redirect.br_taken
                  & fetch_done;

   always_comb begin
      // default is hold
      pc_next = pc_q;
      if (sel_exc) begin
         pc_next = redirect.eentry;
      end else if (sel_ertn) begin
         pc_next = redirect.era;
      end else if (sel_br) begin
         pc_next = redirect.br_target;
      end else if (sel_inc) begin
         pc_next = pc_inc;
      end
   end

   // ========================================================================
   // fetch pc register
   // ========================================================================

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         pc_q <= `IFU_RESET_PC;
      end else begin
         pc_q <= pc_next;
      end
   end

   // address of the current or next bus read
   assign fetch_pc = pc_q;

endmodule

// ==== rtl/ifu_pkg.sv ====
`include "ifu_settings.svh"

package ifu_pkg;

   // ========================================================================
   // core side types
   // ========================================================================

   // instruction address, one word
   typedef logic [`IFU_XLEN-1:0] addr_t;

   // one fetched instruction as handed to decode
   // ex and exccode flag a fetch that failed on the bus
   typedef struct packed {
      addr_t                pc;
      logic [`IFU_XLEN-1:0] inst;
      logic                 ex;
      logic [5:0]           exccode;
   } fetch_bundle_t;

   // redirect pulse from execute
   // except wins over ertn
   // ertn wins over br_taken
   typedef struct packed {
      // exception entry
      logic  except;
      addr_t eentry;
      // exception return
      logic  ertn;
      addr_t era;
      // resolved taken branch
      logic  br_taken;
      addr_t br_target;
   } redirect_t;

endpackage

// ==== rtl/ifu_settings.svh ====
`ifndef IFU_SETTINGS_SVH
`define IFU_SETTINGS_SVH

// ===========================================================================
// fetch unit constants
// ===========================================================================

// word and address width
`define IFU_XLEN 32

// first fetch address after reset
// matches the boot vector of the core
`define IFU_RESET_PC 32'h1c00_0000

// exception code for a fetch that ended in a bus error
// goes into exccode of the bundle
`define IFU_EXC_FETCH_ERR 6'h08

`endif

// ==== rtl/ifu_stage_reg.sv ====
`timescale 1ns/1ps

module ifu_stage_reg #(
   parameter type payload_t = logic
) (
   input  logic     clock,
   input  logic     rst_n,
   input  logic     load,
   input  logic     flush,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     out_valid,
   output payload_t out_data
);

   logic     valid_q;
   payload_t data_q;

   // valid bit
   // flush beats load
   always_ff @(posedge clock) begin
      if (!rst_n || flush) begin
         valid_q <= 1'b0;
      end else if (load) begin
         valid_q <= in_valid;
      end
   end

   // payload
   // only moves for a real item, bubbles leave it alone
   always_ff @(posedge clock) begin
      if (load && in_valid) begin
         data_q <= in_data;
      end
   end

   assign out_valid = valid_q;
   assign out_data  = data_q;

endmodule

// ==== rtl/ifu_top.sv ====
`timescale 1ns/1ps

module ifu_top import ifu_pkg::*, wb_pkg::*; (
   input  logic          clock,
   input  logic          rst_n,
   output wb_req_t       wb_req,
   input  wb_rsp_t       wb_rsp,
   input  redirect_t     redirect,
   input  logic          stall,
   output fetch_bundle_t dec,
   output logic          dec_valid,
   output addr_t         pc_e,
   output addr_t         pc_w,
   output logic          pc_w_valid
);

   addr_t         fetch_pc;
   logic          fetch_done;
   logic          kill;
   logic          buf_valid;
   fetch_bundle_t buf_bundle;
   logic          buf_take;
   logic          dec_load;
   logic          dec_take;
   logic          trail_load;
   logic          pc_e_valid;
   logic          pc_m_valid;
   addr_t         pc_m;

   // ========================================================================
   // input side
   // ========================================================================

   // any redirect kills younger fetches
   assign kill = redirect.except | redirect.ertn | redirect.br_taken;

   ifu_pc_select u_pc_select (
      .clock      (clock),
      .rst_n      (rst_n),
      .redirect   (redirect),
      .fetch_done (fetch_done),
      .fetch_pc   (fetch_pc)
   );

   ifu_wb_fetch u_wb_fetch (
      .clock      (clock),
      .rst_n      (rst_n),
      .fetch_pc   (fetch_pc),
      .kill       (kill),
      .wb_req     (wb_req),
      .wb_rsp     (wb_rsp),
      .buf_valid  (buf_valid),
      .buf_bundle (buf_bundle),
      .buf_take   (buf_take),
      .fetch_done (fetch_done)
   );

   // ========================================================================
   // decode handoff
   // ========================================================================

   // load when empty or drained this cycle
   assign dec_load = ~dec_valid | ~stall;
   // buffer moves only if the redirect does not flush it
   assign buf_take = dec_load & buf_valid & ~kill;

   ifu_stage_reg #(.payload_t(fetch_bundle_t)) u_dec_reg (
      .clock     (clock),
      .rst_n     (rst_n),
      .load      (dec_load),
      .flush     (kill),
      .in_valid  (buf_valid),
      .in_data   (buf_bundle),
      .out_valid (dec_valid),
      .out_data  (dec)
   );

   // ========================================================================
   // pc trail
   // ========================================================================

   // trail advances on stall free cycles only
   assign trail_load = ~stall;
   // item accepted by decode
   assign dec_take = dec_valid & ~stall;

   // execute stage pc
   ifu_stage_reg #(.payload_t(addr_t)) u_d2e_reg (
      .clock     (clock),
      .rst_n     (rst_n),
      .load      (trail_load),
      .flush     (1'b0),
      .in_valid  (dec_take),
      .in_data   (dec.pc),
      .out_valid (pc_e_valid),
      .out_data  (pc_e)
   );

   // memory stage pc
   ifu_stage_reg #(.payload_t(addr_t)) u_e2m_reg (
      .clock     (clock),
      .rst_n     (rst_n),
      .load      (trail_load),
      .flush     (1'b0),
      .in_valid  (pc_e_valid),
      .in_data   (pc_e),
      .out_valid (pc_m_valid),
      .out_data  (pc_m)
   );

   // writeback stage pc
   ifu_stage_reg #(.payload_t(addr_t)) u_m2w_reg (
      .clock     (clock),
      .rst_n     (rst_n),
      .load      (trail_load),
      .flush     (1'b0),
      .in_valid  (pc_m_valid),
      .in_data   (pc_m),
      .out_valid (pc_w_valid),
      .out_data  (pc_w)
   );

endmodule

// ==== rtl/ifu_wb_fetch.sv ====
`timescale 1ns/1ps
`include "ifu_settings.svh"

module ifu_wb_fetch import ifu_pkg::*, wb_pkg::*; (
   input  logic          clock,
   input  logic          rst_n,
   input  addr_t         fetch_pc,
   input  logic          kill,
   output wb_req_t       wb_req,
   input  wb_rsp_t       wb_rsp,
   output logic          buf_valid,
   output fetch_bundle_t buf_bundle,
   input  logic          buf_take,
   output logic          fetch_done
);

   // drop waits out a cycle whose data is no longer wanted
   typedef enum logic [1:0] {
      st_idle,
      st_busy,
      st_drop
   } fetch_state_e;

   fetch_state_e  state_q;
   fetch_state_e  state_d;
   addr_t         adr_q;
   logic          bus_open;
   logic          start;
   logic          done;
   logic          fill;
   logic          buf_valid_q;
   fetch_bundle_t buf_q;

   // ========================================================================
   // bus cycle control
   // ========================================================================

   // new read only with an empty buffer and no redirect
   assign start = (state_q == st_idle) & ~buf_valid_q & ~kill;
   // slave ends the cycle
   assign done = wb_rsp.ack | wb_rsp.err;
   // response lands only if nothing killed it
   assign fill = (state_q == st_busy) & done & ~kill;

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: begin
            if (start) begin
               state_d = st_busy;
            end
         end
         st_busy: begin
            // kill in the ack cycle also discards
            if (done) begin
               state_d = st_idle;
            end else if (kill) begin
               state_d = st_drop;
            end
         end
         st_drop: begin
            if (done) begin
               state_d = st_idle;
            end
         end
         default: begin
            state_d = st_idle;
         end
      endcase
   end

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         state_q <= st_idle;
      end else begin
         state_q <= state_d;
      end
   end

   // address held for the whole cycle
   always_ff @(posedge clock) begin
      if (start) begin
         adr_q <= fetch_pc;
      end
   end

   // read only, full word
   assign bus_open   = (state_q != st_idle);
   assign wb_req.cyc = bus_open;
   assign wb_req.stb = bus_open;
   assign wb_req.we  = 1'b0;
   assign wb_req.sel = 4'hf;
   assign wb_req.adr = adr_q;

   // ========================================================================
   // response buffer
   // ========================================================================

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         buf_valid_q <= 1'b0;
      end else if (kill) begin
         buf_valid_q <= 1'b0;
      end else if (fill) begin
         buf_valid_q <= 1'b1;
      end else if (buf_take) begin
         buf_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clock) begin
      if (fill) begin
         buf_q.pc <= adr_q;
         buf_q.ex <= wb_rsp.err;
         // err carries no instruction
         if (wb_rsp.err) begin
            buf_q.inst    <= '0;
            buf_q.exccode <= `IFU_EXC_FETCH_ERR;
         end else begin
            buf_q.inst    <= wb_rsp.dat;
            buf_q.exccode <= '0;
         end
      end
   end

   assign buf_valid  = buf_valid_q;
   assign buf_bundle = buf_q;
   // tells the pc selector to step by 4
   assign fetch_done = buf_take & buf_valid_q;

endmodule

// ==== rtl/wb_pkg.sv ====
`include "ifu_settings.svh"

package wb_pkg;

   // ========================================================================
   // wishbone classic bus types
   // ========================================================================

   // master to slave
   typedef struct packed {
      logic                 cyc;
      logic                 stb;
      logic                 we;
      logic [3:0]           sel;
      logic [`IFU_XLEN-1:0] adr;
   } wb_req_t;

   // slave to master
   // ack or err ends the cycle, never both
   typedef struct packed {
      logic                 ack;
      logic                 err;
      logic [`IFU_XLEN-1:0] dat;
   } wb_rsp_t;

endpackage
